// File: rx_majority_wrapper.f
source/rx_vote_pkg.sv
source/rx_frame_parser.sv
source/segment_voter.sv
source/segment_vote_bank.sv
source/vote_output_sequencer.sv
source/rx_majority_wrapper.sv
bench/rx_majority_wrapper_tb.sv

// File: bench/rx_majority_wrapper_tb.sv
`timescale 1ns/1ns

module rx_majority_wrapper_tb import rx_vote_pkg::*; ();

	logic clk125MHz;
	logic reset;
	logic [7:0] rx_data;
	logic rx_enable;
	logic [7:0] redundancy;
	logic en_out;
	logic [7:0] data_out;
	logic [15:0] seg_out;

	integer seed;
	int mismatch_count;
	int unexpected_count;
	int timeout_count;
	int frames_sent;
	int bursts_seen;
	int bursts_expected;

	// Reference model state.
	logic [15:0] exp_segs [$];
	payload_t exp_payloads [$];
	payload_t copies [8];
	int byte_pos;
	logic expect_ok;
	logic prev_en;
	logic [7:0] exp_byte;
	logic [15:0] exp_seg;

	rx_majority_wrapper i_rx_majority_wrapper (
		.clk125MHz  (clk125MHz),
		.reset      (reset),
		.rx_data    (rx_data),
		.rx_enable  (rx_enable),
		.redundancy (redundancy),
		.en_out     (en_out),
		.data_out   (data_out),
		.seg_out    (seg_out)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	function automatic payload_t random_payload();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// Sparse random corruption of a payload.
	function automatic payload_t flip_bits(input payload_t p);
		payload_t mask;
		mask = random_payload() & random_payload();
		return p ^ mask;
	endfunction

	// Bitwise majority over copies[first .. first+n-1].
	function automatic payload_t vote_copies(input int first, input int n, input int red);
		payload_t result;
		int ones;
		for (int k = 0; k < PAYLOAD_BYTES; k++) begin
			for (int b = 0; b < 8; b++) begin
				ones = 0;
				for (int c = first; c < first + n; c++) begin
					ones += copies[c][k][b];
				end
				result[k][b] = (2 * ones > red);
			end
		end
		return result;
	endfunction

	task automatic expect_segment(input logic [15:0] seg, input payload_t p);
		exp_segs.push_back(seg);
		exp_payloads.push_back(p);
		bursts_expected++;
	endtask

	// Full frame is header, segment, id, aux, payload. Negative corrupt_at means no damage.
	task automatic send_frame(input logic [15:0] seg, input payload_t p,
		input int corrupt_at, input int length);
		logic [7:0] frame [PAYLOAD_OFFSET + PAYLOAD_BYTES];
		for (int i = 0; i < PAYLOAD_OFFSET + PAYLOAD_BYTES; i++) begin
			frame[i] = 8'(i);
		end
		for (int i = 0; i < 6; i++) begin
			frame[MAC_OFFSET + i] = ETH_DST_MAC[8 * (5 - i) +: 8];
		end
		for (int i = 0; i < 4; i++) begin
			frame[IP_SRC_OFFSET + i] = IP_SRC_ADDR[8 * (3 - i) +: 8];
		end
		frame[MARKER_OFFSET] = FRAME_MARKER[15:8];
		frame[MARKER_OFFSET + 1] = FRAME_MARKER[7:0];
		frame[SEGMENT_OFFSET] = seg[15:8];
		frame[SEGMENT_OFFSET + 1] = seg[7:0];
		frame[SEGMENT_OFFSET + 2] = 8'h11;
		frame[SEGMENT_OFFSET + 3] = 8'h22;
		for (int i = 0; i < PAYLOAD_BYTES; i++) begin
			frame[PAYLOAD_OFFSET + i] = p[i];
		end
		if (corrupt_at >= 0) begin
			frame[corrupt_at] = frame[corrupt_at] ^ 8'h5a;
		end
		frames_sent++;
		for (int i = 0; i < length; i++) begin
			@(negedge clk125MHz);
			rx_enable = 1'b1;
			rx_data = frame[i];
		end
		@(negedge clk125MHz);
		rx_enable = 1'b0;
		rx_data = 8'h00;
		repeat (3) @(negedge clk125MHz);
	endtask

	task automatic send_valid(input logic [15:0] seg, input payload_t p);
		send_frame(seg, p, -1, PAYLOAD_OFFSET + PAYLOAD_BYTES);
	endtask

	task automatic wait_outputs_done(input int limit);
		int cycles;
		cycles = 0;
		while ((exp_segs.size() != 0 || en_out) && cycles < limit) begin
			@(negedge clk125MHz);
			cycles++;
		end
		if (cycles >= limit) begin
			timeout_count++;
			$display("Timeout at %0t ns: expected output bursts did not appear", $time);
		end
	endtask

	// Next expected byte, set up half a cycle before the edge that samples it.
	always @(negedge clk125MHz) begin
		if (reset) begin
			byte_pos = 0;
			expect_ok = 1'b1;
			prev_en = 1'b0;
		end else begin
			if (en_out && !prev_en) begin
				bursts_seen++;
			end
			prev_en = en_out;
			if (en_out && exp_segs.size() == 0) begin
				expect_ok = 1'b0;
			end else if (en_out) begin
				expect_ok = 1'b1;
				exp_byte = exp_payloads[0][byte_pos];
				exp_seg = exp_segs[0];
				if (byte_pos == PAYLOAD_BYTES - 1) begin
					byte_pos = 0;
					void'(exp_segs.pop_front());
					void'(exp_payloads.pop_front());
				end else begin
					byte_pos++;
				end
			end
		end
	end

	a_idle_value: assert property (@(posedge clk125MHz) disable iff (reset)
		!en_out |-> data_out == IDLE_BYTE)
		else begin
			mismatch_count++;
			$display("FAILED at %0t ns: idle data_out %h", $time, $sampled(data_out));
		end

	a_no_early_output: assert property (@(posedge clk125MHz) disable iff (reset)
		frames_sent == 0 |-> !en_out)
		else begin
			unexpected_count++;
			$display("Output appeared at %0t ns before any frame was sent", $time);
		end

	a_expected_burst: assert property (@(posedge clk125MHz) disable iff (reset)
		en_out |-> expect_ok)
		else begin
			unexpected_count++;
			$display("Unexpected output byte at %0t ns with no segment expected", $time);
		end

	a_data_byte: assert property (@(posedge clk125MHz) disable iff (reset)
		en_out && expect_ok |-> data_out == exp_byte)
		else begin
			mismatch_count++;
			$display("FAILED at %0t ns: data_out %h, expected %h",
				$time, $sampled(data_out), $sampled(exp_byte));
		end

	a_segment: assert property (@(posedge clk125MHz) disable iff (reset)
		en_out && expect_ok |-> seg_out == exp_seg)
		else begin
			mismatch_count++;
			$display("FAILED at %0t ns: seg_out %0d, expected %0d",
				$time, $sampled(seg_out), $sampled(exp_seg));
		end

	initial begin
		seed = 10;
		mismatch_count = 0;
		unexpected_count = 0;
		timeout_count = 0;
		frames_sent = 0;
		bursts_seen = 0;
		bursts_expected = 0;
		reset = 1'b1;
		rx_data = 8'h00;
		rx_enable = 1'b0;
		redundancy = 8'd3;
		repeat (10) @(negedge clk125MHz);
		reset = 1'b0;
		repeat (20) @(negedge clk125MHz);

		// Identical copies of segment 1.
		copies[0] = random_payload();
		expect_segment(16'd1, copies[0]);
		for (int i = 0; i < 3; i++) begin
			send_valid(16'd1, copies[0]);
		end
		wait_outputs_done(500);

		// One corrupted copy out of three.
		copies[0] = random_payload();
		copies[1] = flip_bits(copies[0]);
		copies[2] = copies[0];
		expect_segment(16'd3, vote_copies(0, 3, 3));
		for (int i = 0; i < 3; i++) begin
			send_valid(16'd3, copies[i]);
		end
		wait_outputs_done(500);

		// Two corrupted copies out of five.
		redundancy = 8'd5;
		copies[0] = random_payload();
		copies[1] = flip_bits(copies[0]);
		copies[2] = copies[0];
		copies[3] = flip_bits(copies[0]);
		copies[4] = copies[0];
		expect_segment(16'd2, vote_copies(0, 5, 5));
		for (int i = 0; i < 5; i++) begin
			send_valid(16'd2, copies[i]);
		end
		wait_outputs_done(800);
		redundancy = 8'd3;

		// Any rejected frame that counted would complete segment 1 early.
		copies[0] = random_payload();
		send_valid(16'd1, copies[0]);
		send_valid(16'd1, copies[0]);
		send_frame(16'd1, ~copies[0], MAC_OFFSET + 2, PAYLOAD_OFFSET + PAYLOAD_BYTES);
		send_frame(16'd1, ~copies[0], IP_SRC_OFFSET + 1, PAYLOAD_OFFSET + PAYLOAD_BYTES);
		send_frame(16'd1, ~copies[0], MARKER_OFFSET + 1, PAYLOAD_OFFSET + PAYLOAD_BYTES);
		send_frame(16'd1, ~copies[0], -1, PAYLOAD_OFFSET + PAYLOAD_BYTES - 3);
		send_valid(16'd7, ~copies[0]);
		repeat (100) @(negedge clk125MHz);
		expect_segment(16'd1, copies[0]);
		send_valid(16'd1, copies[0]);
		wait_outputs_done(500);

		// Segments 0 and 2 interleaved.
		copies[0] = random_payload();
		copies[1] = copies[0];
		copies[2] = copies[0];
		copies[3] = random_payload();
		copies[4] = flip_bits(copies[3]);
		copies[5] = copies[3];
		expect_segment(16'd0, vote_copies(0, 3, 3));
		expect_segment(16'd2, vote_copies(3, 3, 3));
		for (int i = 0; i < 3; i++) begin
			send_valid(16'd0, copies[i]);
			send_valid(16'd2, copies[i + 3]);
		end
		wait_outputs_done(800);
		send_valid(16'd0, copies[0]);
		repeat (100) @(negedge clk125MHz);

		assert (bursts_seen == bursts_expected)
		else begin
			mismatch_count++;
			$display("FAILED at %0t ns: %0d bursts seen, expected %0d",
				$time, bursts_seen, bursts_expected);
		end

		$display("Errors: mismatches=%0d unexpected=%0d timeouts=%0d",
			mismatch_count, unexpected_count, timeout_count);
		if (mismatch_count == 0 && unexpected_count == 0 && timeout_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: source/rx_majority_wrapper.sv
`timescale 1ns/1ns

module rx_majority_wrapper import rx_vote_pkg::*; (
	input  logic        clk125MHz,
	input  logic        reset,
	input  logic [7:0]  rx_data,
	input  logic        rx_enable,
	input  logic [7:0]  redundancy,
	output logic        en_out,
	output logic [7:0]  data_out,
	output logic [15:0] seg_out
);

	logic copy_valid;
	logic [15:0] copy_segment;
	payload_t copy_payload;
	logic [SEGMENT_COUNT-1:0] segment_ready;
	payload_t voted_payload;
	logic [SEGMENT_INDEX_BITS-1:0] read_segment;
	logic release_pulse;

	rx_frame_parser i_rx_frame_parser (
		.clk125MHz    (clk125MHz),
		.reset        (reset),
		.rx_data      (rx_data),
		.rx_enable    (rx_enable),
		.copy_valid   (copy_valid),
		.copy_segment (copy_segment),
		.copy_payload (copy_payload)
	);

	segment_vote_bank i_segment_vote_bank (
		.clk125MHz     (clk125MHz),
		.reset         (reset),
		.redundancy    (redundancy),
		.copy_valid    (copy_valid),
		.copy_segment  (copy_segment),
		.copy_payload  (copy_payload),
		.read_segment  (read_segment),
		.release_pulse (release_pulse),
		.segment_ready (segment_ready),
		.voted_payload (voted_payload)
	);

	vote_output_sequencer i_vote_output_sequencer (
		.clk125MHz     (clk125MHz),
		.reset         (reset),
		.segment_ready (segment_ready),
		.voted_payload (voted_payload),
		.read_segment  (read_segment),
		.release_pulse (release_pulse),
		.en_out        (en_out),
		.data_out      (data_out),
		.seg_out       (seg_out)
	);

endmodule

// File: source/vote_output_sequencer.sv
`timescale 1ns/1ns

module vote_output_sequencer import rx_vote_pkg::*; (
	input  logic                          clk125MHz,
	input  logic                          reset,
	input  logic [SEGMENT_COUNT-1:0]      segment_ready,
	input  payload_t                      voted_payload,
	output logic [SEGMENT_INDEX_BITS-1:0] read_segment,
	output logic                          release_pulse,
	output logic                          en_out,
	output logic [7:0]                    data_out,
	output logic [15:0]                   seg_out
);

	typedef enum logic {
		SELECT,
		STREAM
	} seq_state_t;

	seq_state_t state;
	logic [PAYLOAD_INDEX_BITS-1:0] byte_index;
	logic [SEGMENT_INDEX_BITS-1:0] lowest_ready;
	logic last_byte;

	// Lowest ready index wins.
	always_comb begin
		lowest_ready = '0;
		for (int i = SEGMENT_COUNT - 1; i >= 0; i--) begin
			if (segment_ready[i]) begin
				lowest_ready = SEGMENT_INDEX_BITS'(i);
			end
		end
	end

	assign last_byte = (byte_index == PAYLOAD_INDEX_BITS'(PAYLOAD_BYTES - 1));

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= SELECT;
			read_segment <= '0;
			byte_index <= '0;
		end else begin
			case (state)
				SELECT: begin
					byte_index <= '0;
					if (|segment_ready) begin
						read_segment <= lowest_ready;
						state <= STREAM;
					end
				end
				STREAM: begin
					byte_index <= byte_index + 1'b1;
					if (last_byte) begin
						state <= SELECT;
					end
				end
				default: state <= SELECT;
			endcase
		end
	end

	assign en_out = (state == STREAM);
	assign release_pulse = en_out && last_byte;
	assign data_out = en_out ? voted_payload[byte_index] : IDLE_BYTE;
	assign seg_out = 16'(read_segment);

	// Each burst is one whole payload, never split or stretched.
	assert property (@(posedge clk125MHz) disable iff (reset)
		$rose(en_out) |-> en_out [*PAYLOAD_BYTES] ##1 !en_out);

endmodule

// File: source/segment_vote_bank.sv
`timescale 1ns/1ns

module segment_vote_bank import rx_vote_pkg::*; (
	input  logic                          clk125MHz,
	input  logic                          reset,
	input  logic [7:0]                    redundancy,
	input  logic                          copy_valid,
	input  logic [15:0]                   copy_segment,
	input  payload_t                      copy_payload,
	input  logic [SEGMENT_INDEX_BITS-1:0] read_segment,
	input  logic                          release_pulse,
	output logic [SEGMENT_COUNT-1:0]      segment_ready,
	output payload_t                      voted_payload
);

	logic [SEGMENT_COUNT-1:0] add_copy;
	logic [SEGMENT_COUNT-1:0] release_slot;
	payload_t slot_payload [SEGMENT_COUNT];

	for (genvar i = 0; i < SEGMENT_COUNT; i++) begin : g_voter
		// Copies for a segment that is already ready are dropped here.
		assign add_copy[i] = copy_valid && (copy_segment == 16'(i)) && !segment_ready[i];
		assign release_slot[i] = release_pulse &&
			(read_segment == SEGMENT_INDEX_BITS'(i));

		segment_voter i_segment_voter (
			.clk125MHz     (clk125MHz),
			.reset         (reset),
			.redundancy    (redundancy),
			.add_copy      (add_copy[i]),
			.copy_payload  (copy_payload),
			.release_pulse (release_slot[i]),
			.ready         (segment_ready[i]),
			.voted_payload (slot_payload[i])
		);
	end

	assign voted_payload = slot_payload[read_segment];

	// The sequencer only frees a slot it has fully read out.
	assert property (@(posedge clk125MHz) disable iff (reset)
		release_pulse |-> segment_ready[read_segment]);

endmodule

// File: source/segment_voter.sv
`timescale 1ns/1ns

module segment_voter import rx_vote_pkg::*; (
	input  logic       clk125MHz,
	input  logic       reset,
	input  logic [7:0] redundancy,
	input  logic       add_copy,
	input  payload_t   copy_payload,
	input  logic       release_pulse,
	output logic       ready,
	output payload_t   voted_payload
);

	logic [PAYLOAD_BITS-1:0] copy_bits;
	logic [PAYLOAD_BITS-1:0] voted_bits;
	logic [7:0] ones_count [PAYLOAD_BITS];
	logic [7:0] copy_count;

	assign copy_bits = copy_payload;
	assign ready = (copy_count == redundancy);

	// Counts never exceed redundancy, so 8 bits cannot overflow.
	always_ff @(posedge clk125MHz) begin
		if (reset || release_pulse) begin
			copy_count <= '0;
			for (int b = 0; b < PAYLOAD_BITS; b++) begin
				ones_count[b] <= '0;
			end
		end else if (add_copy && !ready) begin
			copy_count <= copy_count + 8'd1;
			for (int b = 0; b < PAYLOAD_BITS; b++) begin
				ones_count[b] <= ones_count[b] + {7'd0, copy_bits[b]};
			end
		end
	end

	// Strict majority: twice the ones count beats the number of copies.
	always_comb begin
		for (int b = 0; b < PAYLOAD_BITS; b++) begin
			voted_bits[b] = {ones_count[b], 1'b0} > {1'b0, redundancy};
		end
	end

	assign voted_payload = voted_bits;

	// Bank only adds to voters not yet ready, and only releases ready ones.
	assert property (@(posedge clk125MHz) disable iff (reset)
		!(add_copy && release_pulse));

endmodule

// File: source/rx_frame_parser.sv
`timescale 1ns/1ns

module rx_frame_parser import rx_vote_pkg::*; (
	input  logic       clk125MHz,
	input  logic       reset,
	input  logic [7:0] rx_data,
	input  logic       rx_enable,
	output logic       copy_valid,
	output logic [15:0] copy_segment,
	output payload_t   copy_payload
);

	localparam int LAST_PAYLOAD_COUNT = PAYLOAD_OFFSET + PAYLOAD_BYTES - 1;

	logic [7:0] rx_data_q;
	logic rx_en_q;
	logic [FRAME_COUNT_BITS-1:0] byte_count;
	logic header_ok;
	logic frame_complete;
	logic frame_end;
	logic header_byte;
	logic [7:0] expected_byte;
	logic [PAYLOAD_INDEX_BITS-1:0] payload_index;

	assign payload_index = PAYLOAD_INDEX_BITS'(byte_count - PAYLOAD_OFFSET);

	// Expected value for the header byte now in rx_data_q.
	always_comb begin
		header_byte = 1'b0;
		expected_byte = 8'h00;
		if (byte_count >= MAC_OFFSET && byte_count < MAC_OFFSET + 6) begin
			header_byte = 1'b1;
			expected_byte = ETH_DST_MAC[8 * (MAC_OFFSET + 5 - byte_count) +: 8];
		end else if (byte_count >= IP_SRC_OFFSET && byte_count < IP_SRC_OFFSET + 4) begin
			header_byte = 1'b1;
			expected_byte = IP_SRC_ADDR[8 * (IP_SRC_OFFSET + 3 - byte_count) +: 8];
		end else if (byte_count >= MARKER_OFFSET && byte_count < MARKER_OFFSET + 2) begin
			header_byte = 1'b1;
			expected_byte = FRAME_MARKER[8 * (MARKER_OFFSET + 1 - byte_count) +: 8];
		end
	end

	always_ff @(posedge clk125MHz) begin
		rx_data_q <= rx_data;
		if (reset) begin
			rx_en_q <= 1'b0;
			byte_count <= '0;
			header_ok <= 1'b1;
			frame_complete <= 1'b0;
			frame_end <= 1'b0;
			copy_valid <= 1'b0;
		end else begin
			rx_en_q <= rx_enable;
			// High in the cycle after the last byte was checked.
			frame_end <= rx_en_q && !rx_enable;
			copy_valid <= frame_end && header_ok && frame_complete &&
				(copy_segment < SEGMENT_COUNT);

			if (rx_en_q && rx_enable) begin
				byte_count <= byte_count + 1'b1;
			end else begin
				byte_count <= '0;
			end

			// Flags rearm between frames, after the end decision has read them.
			if (!rx_en_q) begin
				header_ok <= 1'b1;
				frame_complete <= 1'b0;
			end else begin
				if (header_byte && rx_data_q != expected_byte) begin
					header_ok <= 1'b0;
				end
				if (byte_count == LAST_PAYLOAD_COUNT) begin
					frame_complete <= 1'b1;
				end
			end
		end
	end

	// Segment number and payload capture.
	always_ff @(posedge clk125MHz) begin
		if (rx_en_q) begin
			if (byte_count == SEGMENT_OFFSET) begin
				copy_segment[15:8] <= rx_data_q;
			end
			if (byte_count == SEGMENT_OFFSET + 1) begin
				copy_segment[7:0] <= rx_data_q;
			end
			if (byte_count >= PAYLOAD_OFFSET && byte_count <= LAST_PAYLOAD_COUNT) begin
				copy_payload[payload_index] <= rx_data_q;
			end
		end
	end

	// One strobe per frame, even with back-to-back frames.
	assert property (@(posedge clk125MHz) disable iff (reset)
		copy_valid |=> !copy_valid);

	assert property (@(posedge clk125MHz) disable iff (reset)
		copy_valid |-> copy_segment < SEGMENT_COUNT);

endmodule

// File: source/rx_vote_pkg.sv
package rx_vote_pkg;

	// Expected header fields.
	localparam logic [47:0] ETH_DST_MAC = 48'hdeadbeef0123;
	localparam logic [31:0] IP_SRC_ADDR = 32'hc0a80140;
	localparam logic [15:0] FRAME_MARKER = 16'h0102;

	// Byte counts within a frame, counted from 0.
	localparam int MAC_OFFSET = 6;
	localparam int IP_SRC_OFFSET = 26;
	localparam int MARKER_OFFSET = 32;
	localparam int SEGMENT_OFFSET = 34;
	localparam int PAYLOAD_OFFSET = 38;

	// Payload and slot sizes.
	localparam int PAYLOAD_BYTES = 16;
	localparam int PAYLOAD_BITS = PAYLOAD_BYTES * 8;
	localparam int PAYLOAD_INDEX_BITS = $clog2(PAYLOAD_BYTES);
	localparam int SEGMENT_COUNT = 4;
	localparam int SEGMENT_INDEX_BITS = $clog2(SEGMENT_COUNT);

	// Wide enough for a full-size Ethernet frame.
	localparam int FRAME_COUNT_BITS = 12;

	// Output value between bursts.
	localparam logic [7:0] IDLE_BYTE = 8'hff;

	// Byte 0 is the first payload byte on the wire.
	typedef logic [PAYLOAD_BYTES-1:0][7:0] payload_t;

endpackage
